//--- hdl/lsu_pkg.sv
package lsu_pkg;

    // --------------------------------------------------
    // Instruction fields
    // --------------------------------------------------
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Width and signedness codes, bit 2 set means unsigned
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

    // --------------------------------------------------
    // Data path widths
    // --------------------------------------------------
    typedef logic [31:0] word_t;        // One bus word
    typedef logic [3:0]  sel_t;         // Byte selects, bit k for byte k
    typedef logic [1:0]  size_t;        // Access size

    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_HALF = 2'd1;
    localparam size_t SZ_WORD = 2'd2;

    // --------------------------------------------------
    // Bus master FSM
    // --------------------------------------------------
    typedef enum logic [1:0] {
        BUS_IDLE,                       // Waiting for a decoded request
        BUS_ACTIVE,                     // cyc and stb high, waiting for ack
        BUS_DONE                        // Cycle finished, one clock to report
    } bus_state_t;

endpackage

//--- hdl/lsu_access_decode.sv
`timescale 1ns/1ns

module lsu_access_decode #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  lsu_pkg::opcode_t      opcode,
    input  lsu_pkg::funct3_t      funct3,
    input  logic [ADDR_WIDTH-1:0] address,
    input  lsu_pkg::word_t        store_data,
    input  logic                  bus_idle,
    output logic                  dec_valid,
    output logic                  dec_we,
    output logic [ADDR_WIDTH-1:0] dec_adr,
    output lsu_pkg::sel_t         dec_sel,
    output lsu_pkg::word_t        dec_wdata,
    output lsu_pkg::size_t        dec_size,
    output logic                  dec_signed,
    output logic [1:0]            dec_offset,
    output logic                  dec_misaligned,
    output logic                  dec_illegal
);

    logic           busy;               // Request held until the bus goes idle
    logic           accept;
    logic           is_load;
    logic           is_store;
    logic           illegal_c;
    logic           misaligned_c;
    lsu_pkg::size_t size_c;
    lsu_pkg::sel_t  sel_c;
    lsu_pkg::word_t wdata_c;

    assign req_ready = ~busy;
    assign accept    = req_valid & req_ready;
    assign is_load   = (opcode == lsu_pkg::OPC_LOAD);
    assign is_store  = (opcode == lsu_pkg::OPC_STORE);

    // --------------------------------------------------
    // Size and fault checks
    // --------------------------------------------------
    always_comb
    begin
        size_c    = lsu_pkg::SZ_WORD;
        illegal_c = 1'b0;
        case (funct3)
            lsu_pkg::F3_BYTE, lsu_pkg::F3_BYTE_U: size_c = lsu_pkg::SZ_BYTE;
            lsu_pkg::F3_HALF, lsu_pkg::F3_HALF_U: size_c = lsu_pkg::SZ_HALF;
            lsu_pkg::F3_WORD:                     size_c = lsu_pkg::SZ_WORD;
            default:                              illegal_c = 1'b1;     // Codes 3, 6, 7
        endcase
        if (!is_load && !is_store)
            illegal_c = 1'b1;
        if (is_store && funct3[2])
            illegal_c = 1'b1;           // No unsigned store forms
    end

    assign misaligned_c = ~illegal_c &
                          (((size_c == lsu_pkg::SZ_HALF) && address[0]) ||
                           ((size_c == lsu_pkg::SZ_WORD) && (address[1:0] != 2'b00)));

    // Byte selects and store lanes, little-endian
    always_comb
    begin
        sel_c   = '0;
        wdata_c = '0;
        if (!illegal_c && !misaligned_c)
        begin
            case (size_c)
                lsu_pkg::SZ_BYTE:
                begin
                    sel_c   = 4'b0001 << address[1:0];
                    wdata_c = {24'b0, store_data[7:0]} << {address[1:0], 3'b000};
                end
                lsu_pkg::SZ_HALF:
                begin
                    sel_c   = 4'b0011 << {address[1], 1'b0};
                    wdata_c = {16'b0, store_data[15:0]} << {address[1], 4'b0000};
                end
                default:
                begin
                    sel_c   = 4'b1111;
                    wdata_c = store_data;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Request register
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy      <= 1'b0;
            dec_valid <= 1'b0;
        end
        else
        begin
            dec_valid <= accept;
            if (accept)
                busy <= 1'b1;
            else if (bus_idle && !dec_valid)
                busy <= 1'b0;           // Bus master back in IDLE after the response
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dec_we         <= is_store;
            dec_adr        <= {address[ADDR_WIDTH-1:2], 2'b00};
            dec_sel        <= sel_c;
            dec_wdata      <= wdata_c;
            dec_size       <= size_c;
            dec_signed     <= ~funct3[2];
            dec_offset     <= address[1:0];
            dec_misaligned <= misaligned_c;
            dec_illegal    <= illegal_c;
        end
    end

endmodule

//--- hdl/lsu_bus_master.sv
`timescale 1ns/1ns

module lsu_bus_master #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dec_valid,
    input  logic                  dec_fault,
    input  logic                  dec_we,
    input  logic [ADDR_WIDTH-1:0] dec_adr,
    input  lsu_pkg::sel_t         dec_sel,
    input  lsu_pkg::word_t        dec_wdata,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [ADDR_WIDTH-1:0] wb_adr,
    output lsu_pkg::sel_t         wb_sel,
    output lsu_pkg::word_t        wb_dat_w,
    input  lsu_pkg::word_t        wb_dat_r,
    input  logic                  wb_ack,
    output logic                  bus_done,
    output lsu_pkg::word_t        bus_rdata,
    output logic                  bus_idle
);

    lsu_pkg::bus_state_t state;
    logic                fault_r;       // DONE was entered without a bus cycle
    logic                start;
    logic                ack_seen;

    assign bus_idle = (state == lsu_pkg::BUS_IDLE);
    assign start    = bus_idle & dec_valid;
    assign ack_seen = (state == lsu_pkg::BUS_ACTIVE) & wb_ack;

    // A fault reports in its own dec_valid cycle, a bus cycle reports from DONE
    assign bus_done = (start & dec_fault) |
                      ((state == lsu_pkg::BUS_DONE) & ~fault_r);

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= lsu_pkg::BUS_IDLE;
            wb_cyc  <= 1'b0;
            wb_stb  <= 1'b0;
            wb_we   <= 1'b0;
            fault_r <= 1'b0;
        end
        else
        begin
            case (state)
                lsu_pkg::BUS_IDLE:
                begin
                    if (dec_valid)
                    begin
                        fault_r <= dec_fault;
                        if (dec_fault)
                            state <= lsu_pkg::BUS_DONE;     // Skip the bus entirely
                        else
                        begin
                            state  <= lsu_pkg::BUS_ACTIVE;
                            wb_cyc <= 1'b1;
                            wb_stb <= 1'b1;
                            wb_we  <= dec_we;
                        end
                    end
                end
                lsu_pkg::BUS_ACTIVE:
                begin
                    if (wb_ack)
                    begin
                        state  <= lsu_pkg::BUS_DONE;
                        wb_cyc <= 1'b0;             // Drop in the cycle after ack
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                    end
                end
                default:
                    state <= lsu_pkg::BUS_IDLE;     // DONE lasts one clock
            endcase
        end
    end

    // --------------------------------------------------
    // Address, selects and data
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            wb_adr   <= dec_adr;                    // Held until ack
            wb_sel   <= dec_sel;
            wb_dat_w <= dec_wdata;
        end
        if (ack_seen)
            bus_rdata <= wb_dat_r;
    end

endmodule

//--- hdl/lsu_load_align.sv
`timescale 1ns/1ns

module lsu_load_align (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           bus_done,
    input  lsu_pkg::word_t bus_rdata,
    input  logic           dec_we,
    input  lsu_pkg::size_t dec_size,
    input  logic           dec_signed,
    input  logic [1:0]     dec_offset,
    input  logic           dec_misaligned,
    input  logic           dec_illegal,
    output logic           resp_valid,
    output lsu_pkg::word_t load_data,
    output logic           misaligned,
    output logic           illegal
);

    logic [7:0]     lane_b;
    logic [15:0]    lane_h;
    lsu_pkg::word_t ext_c;
    logic           zero_c;             // Nothing to return for stores and faults

    // --------------------------------------------------
    // Lane extraction and extension
    // --------------------------------------------------
    assign lane_b = bus_rdata[{dec_offset, 3'b000} +: 8];
    assign lane_h = bus_rdata[{dec_offset[1], 4'b0000} +: 16];

    always_comb
    begin
        case (dec_size)
            lsu_pkg::SZ_BYTE: ext_c = {{24{dec_signed & lane_b[7]}}, lane_b};
            lsu_pkg::SZ_HALF: ext_c = {{16{dec_signed & lane_h[15]}}, lane_h};
            default:          ext_c = bus_rdata;
        endcase
    end

    assign zero_c = dec_we | dec_misaligned | dec_illegal;

    // --------------------------------------------------
    // Response register
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            resp_valid <= 1'b0;
        else
            resp_valid <= bus_done;     // Single pulse, no back-pressure
    end

    always_ff @(posedge clk)
    begin
        if (bus_done)
        begin
            load_data  <= zero_c ? '0 : ext_c;
            misaligned <= dec_misaligned;
            illegal    <= dec_illegal;
        end
    end

endmodule

//--- hdl/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Request side
    input  logic                  req_valid,
    output logic                  req_ready,
    input  lsu_pkg::opcode_t      opcode,
    input  lsu_pkg::funct3_t      funct3,
    input  logic [ADDR_WIDTH-1:0] address,
    input  lsu_pkg::word_t        store_data,
    // Response side
    output logic                  resp_valid,
    output lsu_pkg::word_t        load_data,
    output logic                  misaligned,
    output logic                  illegal,
    // Wishbone classic master
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [ADDR_WIDTH-1:0] wb_adr,
    output lsu_pkg::sel_t         wb_sel,
    output lsu_pkg::word_t        wb_dat_w,
    input  lsu_pkg::word_t        wb_dat_r,
    input  logic                  wb_ack
);

    // --------------------------------------------------
    // Stage connections
    // --------------------------------------------------
    logic                  dec_valid;
    logic                  dec_we;
    logic [ADDR_WIDTH-1:0] dec_adr;
    lsu_pkg::sel_t         dec_sel;
    lsu_pkg::word_t        dec_wdata;
    lsu_pkg::size_t        dec_size;
    logic                  dec_signed;
    logic [1:0]            dec_offset;
    logic                  dec_misaligned;
    logic                  dec_illegal;
    logic                  dec_fault;
    logic                  bus_done;
    lsu_pkg::word_t        bus_rdata;
    logic                  bus_idle;

    assign dec_fault = dec_misaligned | dec_illegal;    // Either flag skips the bus

    lsu_access_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .opcode         (opcode),
        .funct3         (funct3),
        .address        (address),
        .store_data     (store_data),
        .bus_idle       (bus_idle),
        .dec_valid      (dec_valid),
        .dec_we         (dec_we),
        .dec_adr        (dec_adr),
        .dec_sel        (dec_sel),
        .dec_wdata      (dec_wdata),
        .dec_size       (dec_size),
        .dec_signed     (dec_signed),
        .dec_offset     (dec_offset),
        .dec_misaligned (dec_misaligned),
        .dec_illegal    (dec_illegal)
    );

    lsu_bus_master #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_bus (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_fault (dec_fault),
        .dec_we    (dec_we),
        .dec_adr   (dec_adr),
        .dec_sel   (dec_sel),
        .dec_wdata (dec_wdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .bus_done  (bus_done),
        .bus_rdata (bus_rdata),
        .bus_idle  (bus_idle)
    );

    lsu_load_align u_align (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus_done       (bus_done),
        .bus_rdata      (bus_rdata),
        .dec_we         (dec_we),
        .dec_size       (dec_size),
        .dec_signed     (dec_signed),
        .dec_offset     (dec_offset),
        .dec_misaligned (dec_misaligned),
        .dec_illegal    (dec_illegal),
        .resp_valid     (resp_valid),
        .load_data      (load_data),
        .misaligned     (misaligned),
        .illegal        (illegal)
    );

endmodule

//--- tb/load_store_unit_sva.sv
`timescale 1ns/1ns

module load_store_unit_sva #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  req_valid,
    input logic                  req_ready,
    input lsu_pkg::funct3_t      funct3,
    input logic [ADDR_WIDTH-1:0] address,
    input lsu_pkg::word_t        store_data,
    input logic                  resp_valid,
    input logic                  misaligned,
    input logic                  illegal,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_we,
    input logic [ADDR_WIDTH-1:0] wb_adr,
    input lsu_pkg::sel_t         wb_sel,
    input lsu_pkg::word_t        wb_dat_w,
    input logic                  wb_ack,
    input logic                  bus_done
);

    int unsigned      fail_count = 0;
    logic             pending;          // Accepted and not yet answered
    lsu_pkg::word_t   store_q;
    lsu_pkg::funct3_t funct3_q;
    logic [1:0]       offset_q;

    always @(posedge clk)
    begin
        if (!rst_n)
            pending <= 1'b0;
        else if (req_valid && req_ready)
            pending <= 1'b1;
        else if (resp_valid)
            pending <= 1'b0;
        if (req_valid && req_ready)
        begin
            store_q  <= store_data;
            funct3_q <= funct3;
            offset_q <= address[1:0];
        end
    end

    // Only legal requests reach the bus, so funct3 bits 1:0 give the width
    function automatic lsu_pkg::sel_t expected_sel(lsu_pkg::funct3_t f3, logic [1:0] off);
        case (f3[1:0])
            2'b00:
            begin
                case (off)
                    2'd0:    return 4'b0001;
                    2'd1:    return 4'b0010;
                    2'd2:    return 4'b0100;
                    default: return 4'b1000;
                endcase
            end
            2'b01:   return off[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // Lane k holds store byte k minus the lowest selected lane
    function automatic logic lanes_ok(lsu_pkg::sel_t sel, lsu_pkg::word_t dat,
                                      lsu_pkg::word_t st);
        int         first;
        logic [1:0] j;
        first = 0;
        for (int k = 3; k >= 0; k--)
            if (sel[k])
                first = k;
        for (int k = 0; k < 4; k++)
        begin
            j = 2'(k - first);
            if (sel[k] && dat[5'(8*k) +: 8] != st[{j, 3'b000} +: 8])
                return 1'b0;
        end
        return 1'b1;
    endfunction

    // --------------------------------------------------
    // Wishbone protocol
    // --------------------------------------------------
    cyc_equals_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_cyc == wb_stb)
        else begin fail_count++; $error("wb_cyc and wb_stb differ"); end
    held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_sel) && $stable(wb_we) &&
                              $stable(wb_dat_w))
        else begin fail_count++; $error("bus outputs changed before ack"); end
    drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && wb_ack |=> !wb_stb)
        else begin fail_count++; $error("strobe still high after ack"); end
    word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_adr[1:0] == 2'b00)
        else begin fail_count++; $error("wb_adr not word aligned"); end
    sel_rule: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_sel == expected_sel(funct3_q, offset_q))
        else begin fail_count++; $error("wb_sel does not fit size and offset"); end
    store_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && wb_we |-> lanes_ok(wb_sel, wb_dat_w, store_q))
        else begin fail_count++; $error("store value not in the selected lanes"); end

    // --------------------------------------------------
    // Request and response timing
    // --------------------------------------------------
    ack_to_done: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && wb_ack |=> bus_done)
        else begin fail_count++; $error("no bus_done after ack"); end
    done_to_resp: assert property (@(posedge clk) disable iff (!rst_n)
        bus_done |=> resp_valid)
        else begin fail_count++; $error("no response after bus_done"); end
    fault_timing: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && (misaligned || illegal) |->
            $past(req_valid && req_ready, 2) && !$past(wb_cyc) && !wb_cyc)
        else begin fail_count++; $error("faulting request not answered in 2 cycles"); end
    ready_low_while_held: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> !req_ready)
        else begin fail_count++; $error("req_ready high while a request is held"); end
    resp_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> pending)
        else begin fail_count++; $error("response without a request"); end
    reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) |-> req_ready && !wb_cyc && !resp_valid)
        else begin fail_count++; $error("wrong output state after reset"); end

endmodule

bind load_store_unit load_store_unit_sva #(.ADDR_WIDTH(ADDR_WIDTH)) u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .funct3     (funct3),
    .address    (address),
    .store_data (store_data),
    .resp_valid (resp_valid),
    .misaligned (misaligned),
    .illegal    (illegal),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack),
    .bus_done   (bus_done)
);

//--- tb/tb_load_store_unit.sv
`timescale 1ns/1ns

module tb_load_store_unit;

    localparam int TIMEOUT_CYCLES = 4000;   // About 200 requests at up to 10 cycles, with margin
    localparam int RANDOM_REQS    = 150;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    lsu_pkg::opcode_t      opcode;
    lsu_pkg::funct3_t      funct3;
    logic [31:0]           address;
    lsu_pkg::word_t        store_data;
    logic                  resp_valid;
    lsu_pkg::word_t        load_data;
    logic                  misaligned;
    logic                  illegal;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [31:0]           wb_adr;
    lsu_pkg::sel_t         wb_sel;
    lsu_pkg::word_t        wb_dat_w;
    lsu_pkg::word_t        wb_dat_r = '0;
    logic                  wb_ack = 1'b0;

    lsu_pkg::word_t mem [0:255];            // Wishbone slave storage
    logic [7:0]     mirror [0:1023];        // Byte-addressed reference copy
    logic [1:0]     ack_delay;
    logic [1:0]     stb_cnt;
    int             seed;
    int             errors;
    int             cycle_count = 0;

    load_store_unit #(.ADDR_WIDTH(32)) dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic lsu_pkg::word_t fill_word(int idx);
        return {idx[7:0] ^ 8'h5a, ~idx[7:0], idx[7:0] + 8'h31, idx[7:0] ^ 8'hc3};
    endfunction

    // Bytes per access, zero for the reserved codes
    function automatic int access_bytes(lsu_pkg::funct3_t f3);
        case (f3)
            3'd0, 3'd4: return 1;
            3'd1, 3'd5: return 2;
            3'd2:       return 4;
            default:    return 0;
        endcase
    endfunction

    function automatic lsu_pkg::word_t expected_load(lsu_pkg::funct3_t f3, logic [9:0] a);
        lsu_pkg::word_t raw;
        raw = {mirror[a + 10'd3], mirror[a + 10'd2], mirror[a + 10'd1], mirror[a]};
        case (f3)
            lsu_pkg::F3_BYTE:   return {{24{raw[7]}}, raw[7:0]};
            lsu_pkg::F3_BYTE_U: return {24'b0, raw[7:0]};
            lsu_pkg::F3_HALF:   return {{16{raw[15]}}, raw[15:0]};
            lsu_pkg::F3_HALF_U: return {16'b0, raw[15:0]};
            default:            return raw;
        endcase
    endfunction

    task automatic check_value(string name, lsu_pkg::word_t got, lsu_pkg::word_t exp);
        assert (got == exp)
        else
        begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Wishbone slave with a programmable ack delay
    // --------------------------------------------------
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_ack  <= 1'b0;
            stb_cnt <= 2'd0;
            for (int i = 0; i < 256; i++)
                mem[8'(i)] <= fill_word(i);
        end
        else if (wb_ack)
            wb_ack <= 1'b0;                 // One-cycle ack
        else if (wb_cyc && wb_stb)
        begin
            if (stb_cnt == ack_delay)
            begin
                wb_ack   <= 1'b1;
                stb_cnt  <= 2'd0;
                wb_dat_r <= mem[wb_adr[9:2]];
                if (wb_we)
                    for (int k = 0; k < 4; k++)
                        if (wb_sel[k])
                            mem[wb_adr[9:2]][5'(8*k) +: 8] <= wb_dat_w[5'(8*k) +: 8];
            end
            else
                stb_cnt <= stb_cnt + 2'd1;
        end
    end

    task automatic run_request(lsu_pkg::opcode_t op, lsu_pkg::funct3_t f3,
                               logic [31:0] addr, lsu_pkg::word_t data);
        int             nbytes;
        int             rnd;
        logic           exp_ill;
        logic           exp_mis;
        logic [9:0]     ba;
        lsu_pkg::word_t exp_data;
        nbytes   = access_bytes(f3);
        exp_ill  = (op != lsu_pkg::OPC_LOAD && op != lsu_pkg::OPC_STORE) || (nbytes == 0) ||
                   (op == lsu_pkg::OPC_STORE && f3[2]);
        exp_mis  = !exp_ill && ((addr[1:0] & 2'(nbytes - 1)) != 2'b00);
        exp_data = '0;
        if (!exp_ill && !exp_mis && op == lsu_pkg::OPC_LOAD)
            exp_data = expected_load(f3, addr[9:0]);
        rnd = $random(seed);
        @(posedge clk);
        req_valid  <= 1'b1;
        opcode     <= op;
        funct3     <= f3;
        address    <= addr;
        store_data <= data;
        ack_delay  <= rnd[1:0];
        @(posedge clk);
        while (!req_ready)
            @(posedge clk);
        req_valid <= 1'b0;                  // Accepted at this edge
        if (!exp_ill && !exp_mis && op == lsu_pkg::OPC_STORE)
            for (int i = 0; i < nbytes; i++)
            begin
                ba         = addr[9:0] + 10'(i);
                mirror[ba] = data[5'(8*i) +: 8];
            end
        @(posedge clk);
        while (!resp_valid)
            @(posedge clk);
        check_value("misaligned", {31'b0, misaligned}, {31'b0, exp_mis});
        check_value("illegal", {31'b0, illegal}, {31'b0, exp_ill});
        check_value("load_data", load_data, exp_data);
    endtask

    task automatic compare_memory();
        lsu_pkg::word_t mirror_word;
        for (int w = 0; w < 256; w++)
        begin
            for (int k = 0; k < 4; k++)
                mirror_word[5'(8*k) +: 8] = mirror[10'(4*w + k)];
            check_value($sformatf("mem[%0d]", w), mem[8'(w)], mirror_word);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial
    begin
        lsu_pkg::word_t   w;
        lsu_pkg::opcode_t op;
        int               r_ctl;
        int               r_addr;
        int               r_data;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        opcode     = '0;
        funct3     = '0;
        address    = '0;
        store_data = '0;
        ack_delay  = 2'd0;
        seed       = 52;
        errors     = 0;
        for (int i = 0; i < 256; i++)
        begin
            w = fill_word(i);
            for (int k = 0; k < 4; k++)
                mirror[10'(4*i + k)] = w[5'(8*k) +: 8];
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Word store, then every width and signedness over it
        run_request(lsu_pkg::OPC_STORE, lsu_pkg::F3_WORD, 32'h040, 32'h8765_43a1);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_WORD, 32'h040, '0);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_BYTE, 32'h041, '0);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_BYTE, 32'h043, '0);     // Negative byte
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_BYTE_U, 32'h043, '0);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_HALF, 32'h042, '0);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_HALF_U, 32'h042, '0);
        run_request(lsu_pkg::OPC_STORE, lsu_pkg::F3_HALF, 32'h082, 32'h1234_f00d);
        run_request(lsu_pkg::OPC_STORE, lsu_pkg::F3_HALF, 32'h080, 32'hffff_7e11);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_HALF, 32'h082, '0);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_HALF_U, 32'h082, '0);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_HALF, 32'h080, '0);
        for (int k = 0; k < 4; k++)
        begin
            run_request(lsu_pkg::OPC_STORE, lsu_pkg::F3_BYTE, 32'h100 + k, 32'h0000_0070 + 32 * k);
            run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_BYTE, 32'h100 + k, '0);
            run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_BYTE_U, 32'h100 + k, '0);
        end
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_WORD, 32'h100, '0);

        // Faults, none of which may touch the bus
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_HALF, 32'h101, '0);
        run_request(lsu_pkg::OPC_STORE, lsu_pkg::F3_WORD, 32'h102, 32'hdead_beef);
        run_request(lsu_pkg::OPC_LOAD, lsu_pkg::F3_WORD, 32'h103, '0);
        run_request(7'h33, lsu_pkg::F3_WORD, 32'h100, '0);
        run_request(lsu_pkg::OPC_LOAD, 3'd3, 32'h100, '0);
        run_request(lsu_pkg::OPC_LOAD, 3'd6, 32'h100, '0);
        run_request(lsu_pkg::OPC_STORE, lsu_pkg::F3_BYTE_U, 32'h100, 32'h0000_00aa);

        for (int n = 0; n < RANDOM_REQS; n++)
        begin
            r_ctl  = $random(seed);
            r_addr = $random(seed);
            r_data = $random(seed);
            if (r_ctl[3:0] == 4'd0)
                op = 7'h13;                 // Occasional non-memory opcode
            else
                op = r_ctl[8] ? lsu_pkg::OPC_STORE : lsu_pkg::OPC_LOAD;
            run_request(op, r_ctl[6:4], {22'b0, r_addr[9:0]}, r_data);
        end

        compare_memory();
        $display("Errors: %0d data, %0d assertion", errors, dut.u_sva.fail_count);
        if (errors == 0 && dut.u_sva.fail_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

//--- flist.f
hdl/lsu_pkg.sv
hdl/lsu_access_decode.sv
hdl/lsu_bus_master.sv
hdl/lsu_load_align.sv
hdl/load_store_unit.sv
tb/load_store_unit_sva.sv
tb/tb_load_store_unit.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_load_store_unit
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
